// File: hw/soc_pkg.sv
// all accesses are full words; every slot maps SLOT_MAPSZ words and the UART queue depth must be a power of two no larger than 15
`default_nettype none

package soc_pkg;

	// bus geometry
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;
	localparam int SLOT_W = 2;
	localparam int OFFS_W = 6;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [OFFS_W-1:0] offs_t;
	typedef logic [7:0] byte_t;

	// slot map, selected by the upper address bits
	localparam logic [SLOT_W-1:0] SLOT_DEVTBL = 2'd0;
	localparam logic [SLOT_W-1:0] SLOT_GPIO = 2'd1;
	localparam logic [SLOT_W-1:0] SLOT_UART = 2'd2;
	localparam logic [SLOT_W-1:0] SLOT_INVALID = 2'd3;
	localparam int SLOT_COUNT = 4;

	// device ids as reported by the device table
	localparam byte_t DEV_ID_INVALID = 8'd0;
	localparam byte_t DEV_ID_UART = 8'd5;
	localparam byte_t DEV_ID_GPIO = 8'd6;
	localparam byte_t DEV_ID_DEVTBL = 8'd7;

	// map size in words, same for every slot
	localparam int SLOT_MAPSZ = 64;

	// software reset request register sits at the top of the table
	localparam offs_t DEVTBL_CTRL_OFFS = 6'd63;

	localparam int GPIO_COUNT = 8;

	// reset hold of 2**RST_CNTR_W - 1 cycles
	localparam int RST_CNTR_W = 4;

	// transmit path
	localparam int UART_CLKS_PER_BIT = 4;
	localparam int UART_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// File: hw/reset_seq.sv
// holds dev_rst_o for 15 cycles after rst_p or a warm/cold request; power-off keeps it high until the next rst_p
`default_nettype none

module reset_seq import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic rst_req0_i,
	input  logic rst_req1_i,
	output logic dev_rst_o
);

	logic [RST_CNTR_W-1:0] cntr_q;
	logic pwroff_q;
	logic sw_warm;
	logic sw_cold;
	logic sw_pwroff;

	// request decode, cold acts like warm since there is no global set/reset here
	assign sw_cold = rst_req0_i & rst_req1_i;
	assign sw_warm = ~rst_req0_i & rst_req1_i;
	assign sw_pwroff = rst_req0_i & ~rst_req1_i;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			cntr_q <= '1;
			pwroff_q <= 1'b0;
		end else begin
			// the request bits linger one cycle into the reset they cause,
			// so only restart from an idle counter
			if ((sw_warm || sw_cold) && cntr_q == '0)
				cntr_q <= '1;
			else if (cntr_q != '0)
				cntr_q <= cntr_q - 1'b1;
			// stays set until the external reset
			if (sw_pwroff)
				pwroff_q <= 1'b1;
		end
	end

	assign dev_rst_o = (cntr_q != '0) | pwroff_q;

endmodule

`default_nettype wire

// File: hw/bus_decoder.sv
// Wishbone classic with one master; the master holds its request until ack and drops stb the cycle after
`default_nettype none

module bus_decoder import soc_pkg::*; (
	input  logic              clk100mhz_i,
	input  logic              rst_p,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic              wb_we_i,
	input  logic [ADDR_W-1:0] wb_adr_i,
	input  data_t             wb_dat_i,
	output data_t             wb_dat_o,
	output logic              wb_ack_o,
	output offs_t             offs_o,
	output data_t             wdat_o,
	output logic              we_o,
	output logic              dt_stb_o,
	input  data_t             dt_dat_i,
	input  logic              dt_ack_i,
	output logic              gp_stb_o,
	input  data_t             gp_dat_i,
	input  logic              gp_ack_i,
	output logic              ut_stb_o,
	input  data_t             ut_dat_i,
	input  logic              ut_ack_i
);

	logic [SLOT_W-1:0] slot;
	logic req;
	logic inv_ack_q;

	assign slot = wb_adr_i[ADDR_W-1 -: SLOT_W];
	assign req = wb_cyc_i & wb_stb_i;

	// shared request lines to every slave
	assign offs_o = wb_adr_i[OFFS_W-1:0];
	assign wdat_o = wb_dat_i;
	assign we_o = wb_we_i;

	assign dt_stb_o = req && slot == SLOT_DEVTBL;
	assign gp_stb_o = req && slot == SLOT_GPIO;
	assign ut_stb_o = req && slot == SLOT_UART;

	// invalid device answers everything, writes are dropped
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p)
			inv_ack_q <= 1'b0;
		else
			inv_ack_q <= req && slot == SLOT_INVALID && !inv_ack_q;
	end

	always_comb begin
		case (slot)
			SLOT_DEVTBL: begin
				wb_dat_o = dt_dat_i;
				wb_ack_o = dt_ack_i;
			end
			SLOT_GPIO: begin
				wb_dat_o = gp_dat_i;
				wb_ack_o = gp_ack_i;
			end
			SLOT_UART: begin
				wb_dat_o = ut_dat_i;
				wb_ack_o = ut_ack_i;
			end
			// unmapped space reads zero
			default: begin
				wb_dat_o = '0;
				wb_ack_o = inv_ack_q;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/dev_table.sv
// read-only table at offsets 2n and 2n+1 per slot; the request bits at DEVTBL_CTRL_OFFS clear on dev_rst_i
`default_nettype none

module dev_table import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic dev_rst_i,
	input  logic stb_i,
	input  logic we_i,
	input  offs_t offs_i,
	input  data_t dat_i,
	output data_t dat_o,
	output logic ack_o,
	output logic rst_req0_o,
	output logic rst_req1_o
);

	logic [SLOT_W-1:0] slot_idx;
	logic slot_hit;
	data_t rd_word;

	function automatic byte_t dev_id(input logic [SLOT_W-1:0] slot);
		case (slot)
			SLOT_DEVTBL: return DEV_ID_DEVTBL;
			SLOT_GPIO: return DEV_ID_GPIO;
			SLOT_UART: return DEV_ID_UART;
			default: return DEV_ID_INVALID;
		endcase
	endfunction

	// two words per slot
	assign slot_idx = offs_i[SLOT_W:1];
	assign slot_hit = offs_i[OFFS_W-1:1] < SLOT_COUNT;

	always_comb begin
		rd_word = '0;
		if (offs_i == DEVTBL_CTRL_OFFS) begin
			rd_word[1:0] = {rst_req1_o, rst_req0_o};
		end else if (slot_hit) begin
			if (offs_i[0]) begin
				rd_word = data_t'(SLOT_MAPSZ);
			end else begin
				rd_word[7:0] = dev_id(slot_idx);
				// only gpio and uart would raise interrupts
				rd_word[DATA_W-1] = slot_idx == SLOT_GPIO || slot_idx == SLOT_UART;
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (dev_rst_i) begin
			ack_o <= 1'b0;
			rst_req0_o <= 1'b0;
			rst_req1_o <= 1'b0;
		end else begin
			ack_o <= stb_i & ~ack_o;
			if (stb_i && we_i && !ack_o && offs_i == DEVTBL_CTRL_OFFS) begin
				rst_req0_o <= dat_i[0];
				rst_req1_o <= dat_i[1];
			end
		end
	end

	always_ff @(posedge clk100mhz_i)
		dat_o <= rd_word;

endmodule

`default_nettype wire

// File: hw/gpio_port.sv
// offset 0 is the output register and offset 1 the input word, which lags gp_i by two cycles
`default_nettype none

module gpio_port import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic dev_rst_i,
	input  logic stb_i,
	input  logic we_i,
	input  offs_t offs_i,
	input  data_t dat_i,
	input  logic [GPIO_COUNT-1:0] gp_i,
	output data_t dat_o,
	output logic ack_o,
	output logic [GPIO_COUNT-1:0] gp_o
);

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;

	always_ff @(posedge clk100mhz_i) begin
		if (dev_rst_i) begin
			ack_o <= 1'b0;
			gp_o <= '0;
		end else begin
			ack_o <= stb_i & ~ack_o;
			if (stb_i && we_i && !ack_o && offs_i == 6'd0)
				gp_o <= dat_i[GPIO_COUNT-1:0];
		end
	end

	// two flop synchronizer on the pins, then the read mux
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		case (offs_i)
			6'd0: dat_o <= data_t'(gp_o);
			6'd1: dat_o <= data_t'(sync2_q);
			default: dat_o <= '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/uart_tx_queue.sv
// reset by rst_p only so queued bytes survive a software reset; a data write to a full queue waits for a free entry
`default_nettype none

module uart_tx_queue import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic stb_i,
	input  logic we_i,
	input  offs_t offs_i,
	input  data_t dat_i,
	output data_t dat_o,
	output logic ack_o,
	output byte_t byte_o,
	output logic valid_o,
	input  logic ready_i
);

	byte_t mem [UART_FIFO_DEPTH];
	logic [$clog2(UART_FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(UART_FIFO_DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(UART_FIFO_DEPTH+1)-1:0] count_q;
	logic full;
	logic empty;
	logic data_wr;
	logic push;
	logic pop;
	data_t status;

	assign full = count_q == UART_FIFO_DEPTH;
	assign empty = count_q == '0;

	assign data_wr = stb_i && we_i && !ack_o && offs_i == 6'd0;
	assign push = data_wr && !full;
	assign pop = valid_o && ready_i;

	// head of the queue goes straight to the phy
	assign byte_o = mem[rd_ptr_q];
	assign valid_o = !empty;

	always_comb begin
		status = '0;
		status[3:0] = 4'(count_q);
		status[8] = empty;
		status[9] = full;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			ack_o <= 1'b0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			// hold ack back while the write cannot be stored
			ack_o <= stb_i && !ack_o && !(data_wr && full);
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + push - pop;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (push)
			mem[wr_ptr_q] <= dat_i[7:0];
		dat_o <= (offs_i == 6'd1) ? status : '0;
	end

endmodule

`default_nettype wire

// File: hw/uart_tx_phy.sv
// 8N1 at UART_CLKS_PER_BIT cycles per bit, which must be at least 2; the idle cycle before a new byte is the last stop cycle
`default_nettype none

module uart_tx_phy import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  byte_t byte_i,
	input  logic valid_i,
	output logic ready_o,
	output logic uart_tx_o
);

	logic busy_q;
	logic [9:0] shift_q;
	logic [3:0] bit_idx_q;
	logic [$clog2(UART_CLKS_PER_BIT)-1:0] clk_cnt_q;
	logic last_bit;
	logic bit_end;

	// stop bit is cut one cycle short, the idle cycle makes up the rest
	assign last_bit = bit_idx_q == 4'd9;
	assign bit_end = last_bit ? clk_cnt_q == UART_CLKS_PER_BIT - 2
		: clk_cnt_q == UART_CLKS_PER_BIT - 1;

	assign ready_o = !busy_q;
	assign uart_tx_o = busy_q ? shift_q[0] : 1'b1;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			busy_q <= 1'b0;
			bit_idx_q <= '0;
			clk_cnt_q <= '0;
		end else if (!busy_q) begin
			if (valid_i) begin
				busy_q <= 1'b1;
				bit_idx_q <= '0;
				clk_cnt_q <= '0;
			end
		end else if (bit_end) begin
			clk_cnt_q <= '0;
			bit_idx_q <= bit_idx_q + 1'b1;
			if (last_bit)
				busy_q <= 1'b0;
		end else begin
			clk_cnt_q <= clk_cnt_q + 1'b1;
		end
	end

	// frame is start, data lsb first, stop
	always_ff @(posedge clk100mhz_i) begin
		if (!busy_q && valid_i)
			shift_q <= {1'b1, byte_i, 1'b0};
		else if (busy_q && bit_end)
			shift_q <= {1'b1, shift_q[9:1]};
	end

endmodule

`default_nettype wire

// File: hw/soc_top.sv
// single clock at clk100mhz_i; the bus is Wishbone classic with full-word accesses only
`default_nettype none

module soc_top import soc_pkg::*; (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [ADDR_W-1:0] wb_adr_i,
	input  data_t wb_dat_i,
	output data_t wb_dat_o,
	output logic wb_ack_o,
	input  logic [GPIO_COUNT-1:0] gp_i,
	output logic [GPIO_COUNT-1:0] gp_o,
	output logic uart_tx_o,
	output logic dev_rst_o
);

	offs_t offs;
	data_t wdat;
	logic we;
	logic dt_stb;
	data_t dt_dat;
	logic dt_ack;
	logic gp_stb;
	data_t gp_dat;
	logic gp_ack;
	logic ut_stb;
	data_t ut_dat;
	logic ut_ack;
	logic rst_req0;
	logic rst_req1;
	byte_t tx_byte;
	logic tx_valid;
	logic tx_ready;

	reset_seq u_reset_seq (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.rst_req0_i  (rst_req0)
		,.rst_req1_i  (rst_req1)
		,.dev_rst_o   (dev_rst_o)
	);

	bus_decoder u_bus_decoder (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.wb_cyc_i    (wb_cyc_i)
		,.wb_stb_i    (wb_stb_i)
		,.wb_we_i     (wb_we_i)
		,.wb_adr_i    (wb_adr_i)
		,.wb_dat_i    (wb_dat_i)
		,.wb_dat_o    (wb_dat_o)
		,.wb_ack_o    (wb_ack_o)
		,.offs_o      (offs)
		,.wdat_o      (wdat)
		,.we_o        (we)
		,.dt_stb_o    (dt_stb)
		,.dt_dat_i    (dt_dat)
		,.dt_ack_i    (dt_ack)
		,.gp_stb_o    (gp_stb)
		,.gp_dat_i    (gp_dat)
		,.gp_ack_i    (gp_ack)
		,.ut_stb_o    (ut_stb)
		,.ut_dat_i    (ut_dat)
		,.ut_ack_i    (ut_ack)
	);

	dev_table u_dev_table (
		 .clk100mhz_i (clk100mhz_i)
		,.dev_rst_i   (dev_rst_o)
		,.stb_i       (dt_stb)
		,.we_i        (we)
		,.offs_i      (offs)
		,.dat_i       (wdat)
		,.dat_o       (dt_dat)
		,.ack_o       (dt_ack)
		,.rst_req0_o  (rst_req0)
		,.rst_req1_o  (rst_req1)
	);

	gpio_port u_gpio_port (
		 .clk100mhz_i (clk100mhz_i)
		,.dev_rst_i   (dev_rst_o)
		,.stb_i       (gp_stb)
		,.we_i        (we)
		,.offs_i      (offs)
		,.dat_i       (wdat)
		,.gp_i        (gp_i)
		,.dat_o       (gp_dat)
		,.ack_o       (gp_ack)
		,.gp_o        (gp_o)
	);

	// the uart path sees only the external reset
	uart_tx_queue u_uart_tx_queue (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.stb_i       (ut_stb)
		,.we_i        (we)
		,.offs_i      (offs)
		,.dat_i       (wdat)
		,.dat_o       (ut_dat)
		,.ack_o       (ut_ack)
		,.byte_o      (tx_byte)
		,.valid_o     (tx_valid)
		,.ready_i     (tx_ready)
	);

	uart_tx_phy u_uart_tx_phy (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.byte_i      (tx_byte)
		,.valid_i     (tx_valid)
		,.ready_o     (tx_ready)
		,.uart_tx_o   (uart_tx_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_bus_tasks.svh
// Wishbone classic master and UART sampler for tb_soc; they use its clk, bus variables and errors
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// one classic cycle, returns read data and the cycles from strobe to ack
task automatic bus_access(
	input logic [ADDR_W-1:0] adr,
	input logic we,
	input data_t wdat,
	output data_t rdat,
	output int lat
);
	lat = 0;
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = we;
	wb_adr = adr;
	wb_wdat = wdat;
	do begin
		@(negedge clk);
		lat++;
	end while (!wb_ack && lat < BUS_LIMIT);
	rdat = wb_rdat;
	// stb low before the next rising edge
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
	if (!wb_ack) begin
		$display("bus access to address %h got no ack within %0d cycles", adr, BUS_LIMIT);
		errors++;
	end
endtask

task automatic bus_write(input logic [ADDR_W-1:0] adr, input data_t wdat, output int lat);
	data_t ignored;
	bus_access(adr, 1'b1, wdat, ignored, lat);
endtask

task automatic bus_read(input logic [ADDR_W-1:0] adr, output data_t rdat, output int lat);
	bus_access(adr, 1'b0, '0, rdat, lat);
endtask

// samples every cycle of a frame, the first sample of a bit sets its value
task automatic receive_frame(output byte_t b);
	logic [9:0] frame;
	logic glitch;
	int n;
	frame = '0;
	glitch = 1'b0;
	n = 0;
	b = '0;
	while (uart_tx && n < FRAME_WAIT) begin
		@(negedge clk);
		n++;
	end
	if (uart_tx) begin
		$display("no start bit on uart_tx_o within %0d cycles at %0t ns", FRAME_WAIT, $time);
		errors++;
		return;
	end
	for (int k = 0; k < 10 * UART_CLKS_PER_BIT; k++) begin
		if (k > 0)
			@(negedge clk);
		if (k % UART_CLKS_PER_BIT == 0)
			frame[k / UART_CLKS_PER_BIT] = uart_tx;
		else if (uart_tx !== frame[k / UART_CLKS_PER_BIT])
			glitch = 1'b1;
	end
	assert (!glitch && frame[0] == 1'b0 && frame[9] == 1'b1)
	else begin
		$display("bad uart frame before %0t ns: start, stop or bit length wrong", $time);
		errors++;
	end
	b = frame[8:1];
endtask

`endif

// File: sim/tb_soc.sv
// drives soc_top on the falling clock edge; needs the package compiled first and stops after TIMEOUT_CYCLES
`default_nettype none

module tb_soc import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// all tests together run well under 1000 cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int BUS_LIMIT = 100;
	localparam int FRAME_WAIT = 200;
	// the reset counter runs from all ones down to zero
	localparam int RST_HOLD = 2 ** RST_CNTR_W - 1;
	localparam int STREAM_BYTES = 6;

	logic clk;
	logic rst_p;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADDR_W-1:0] wb_adr;
	data_t wb_wdat;
	data_t wb_rdat;
	logic wb_ack;
	logic [GPIO_COUNT-1:0] gp_in;
	logic [GPIO_COUNT-1:0] gp_out;
	logic uart_tx;
	logic dev_rst;

	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_base = 0;
	int cycles;
	logic stb_q;
	logic powerup_q;

	soc_top u_soc_top (
		 .clk100mhz_i (clk)
		,.rst_p       (rst_p)
		,.wb_cyc_i    (wb_cyc)
		,.wb_stb_i    (wb_stb)
		,.wb_we_i     (wb_we)
		,.wb_adr_i    (wb_adr)
		,.wb_dat_i    (wb_wdat)
		,.wb_dat_o    (wb_rdat)
		,.wb_ack_o    (wb_ack)
		,.gp_i        (gp_in)
		,.gp_o        (gp_out)
		,.uart_tx_o   (uart_tx)
		,.dev_rst_o   (dev_rst)
	);

	`include "tb_bus_tasks.svh"

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// stb as seen by the slaves, and the power-up window from rst_p to the end of dev_rst_o
	always_ff @(posedge clk) begin
		stb_q <= wb_stb;
		if (rst_p)
			powerup_q <= 1'b1;
		else if (!dev_rst)
			powerup_q <= 1'b0;
	end

	// sampled on the falling edge where the DUT outputs are settled
	ack_single: assert property (@(negedge clk) (!powerup_q && wb_ack) |=> !wb_ack)
	else begin
		$display("wb_ack_o was high in two consecutive cycles at %0t ns", $time);
		errors++;
	end

	ack_with_stb: assert property (@(negedge clk) (!powerup_q && wb_ack) |-> stb_q)
	else begin
		$display("wb_ack_o rose without a strobe at %0t ns", $time);
		errors++;
	end

	tx_idle_powerup: assert property (@(negedge clk) (powerup_q && dev_rst) |-> uart_tx)
	else begin
		$display("uart_tx_o left idle during power-up at %0t ns", $time);
		errors++;
	end

	task automatic check_value(input string name, input data_t got, input data_t exp);
		assert (got === exp)
		else begin
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != test_base)
			failed_tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_base) ? "passed" : "FAILED");
		test_base = errors;
	endtask

	function automatic logic [ADDR_W-1:0] slot_addr(input logic [SLOT_W-1:0] slot, input int offs);
		return {slot, OFFS_W'(offs)};
	endfunction

	// id in the low byte, interrupt use in bit 31 for gpio and uart
	function automatic data_t table_id_word(input int n);
		data_t w;
		w = '0;
		if (n == SLOT_DEVTBL) begin
			w[7:0] = DEV_ID_DEVTBL;
		end else if (n == SLOT_GPIO) begin
			w[7:0] = DEV_ID_GPIO;
			w[31] = 1'b1;
		end else if (n == SLOT_UART) begin
			w[7:0] = DEV_ID_UART;
			w[31] = 1'b1;
		end else begin
			w[7:0] = DEV_ID_INVALID;
		end
		return w;
	endfunction

	task automatic apply_reset();
		rst_p = 1'b1;
		repeat (5) @(negedge clk);
		rst_p = 1'b0;
	endtask

	task automatic wait_reset_rise();
		int n;
		n = 0;
		while (!dev_rst && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!dev_rst) begin
			$display("dev_rst_o did not rise after a reset request at %0t ns", $time);
			errors++;
		end
	endtask

	// cycles from now until dev_rst_o is seen low
	task automatic check_reset_hold();
		int n;
		n = 0;
		while (dev_rst && n < 200) begin
			@(negedge clk);
			n++;
		end
		check_value("dev_rst_o high cycles", data_t'(n), data_t'(RST_HOLD));
	endtask

	initial begin
		data_t rd;
		data_t w;
		int lat;
		int held;
		logic [GPIO_COUNT-1:0] pat;
		byte_t sent [STREAM_BYTES];
		byte_t got [STREAM_BYTES];
		int lats [STREAM_BYTES];

		clk = 1'b0;
		rst_p = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		gp_in = '0;
		void'($urandom(97418));

		apply_reset();
		check_reset_hold();
		check_value("uart_tx_o", data_t'(uart_tx), 32'd1);
		check_value("gp_o", data_t'(gp_out), 32'd0);
		check_value("wb_ack_o", data_t'(wb_ack), 32'd0);
		finish_test("reset sequence");

		for (int n = 0; n < SLOT_COUNT; n++) begin
			bus_read(slot_addr(SLOT_DEVTBL, 2 * n), rd, lat);
			check_value("wb_dat_o", rd, table_id_word(n));
			check_value("wb_ack_o latency", data_t'(lat), 32'd1);
			bus_read(slot_addr(SLOT_DEVTBL, 2 * n + 1), rd, lat);
			check_value("wb_dat_o", rd, data_t'(SLOT_MAPSZ));
			check_value("wb_ack_o latency", data_t'(lat), 32'd1);
		end
		bus_read(slot_addr(SLOT_DEVTBL, 2 * SLOT_COUNT), rd, lat);
		check_value("wb_dat_o", rd, 32'd0);
		bus_read(slot_addr(SLOT_DEVTBL, DEVTBL_CTRL_OFFS), rd, lat);
		check_value("wb_dat_o", rd, 32'd0);
		bus_read(slot_addr(SLOT_INVALID, int'($urandom_range(63))), rd, lat);
		check_value("wb_dat_o", rd, 32'd0);
		check_value("wb_ack_o latency", data_t'(lat), 32'd1);
		// offsets that hold writable registers in the other slots
		bus_write(slot_addr(SLOT_INVALID, 0), $urandom | 32'h1, lat);
		check_value("wb_ack_o latency", data_t'(lat), 32'd1);
		bus_write(slot_addr(SLOT_INVALID, DEVTBL_CTRL_OFFS), 32'h3, lat);
		check_value("wb_ack_o latency", data_t'(lat), 32'd1);
		bus_read(slot_addr(SLOT_GPIO, 0), rd, lat);
		check_value("wb_dat_o", rd, 32'd0);
		bus_read(slot_addr(SLOT_DEVTBL, DEVTBL_CTRL_OFFS), rd, lat);
		check_value("wb_dat_o", rd, 32'd0);
		// an empty queue reports only the empty flag in bit 8
		bus_read(slot_addr(SLOT_UART, 1), rd, lat);
		check_value("wb_dat_o", rd, 32'h100);
		check_value("dev_rst_o", data_t'(dev_rst), 32'd0);
		finish_test("device table");

		repeat (4) begin
			w = $urandom;
			bus_write(slot_addr(SLOT_GPIO, 0), w, lat);
			check_value("gp_o", data_t'(gp_out), data_t'(w[GPIO_COUNT-1:0]));
			bus_read(slot_addr(SLOT_GPIO, 0), rd, lat);
			check_value("wb_dat_o", rd, data_t'(w[GPIO_COUNT-1:0]));
		end
		repeat (3) begin
			pat = GPIO_COUNT'($urandom);
			@(negedge clk);
			gp_in = pat;
			// the read strobe is sampled two cycles after the change
			repeat (1) @(negedge clk);
			bus_read(slot_addr(SLOT_GPIO, 1), rd, lat);
			check_value("wb_dat_o", rd, data_t'(pat));
		end
		finish_test("gpio");

		for (int i = 0; i < STREAM_BYTES; i++)
			sent[i] = byte_t'($urandom);
		fork
			begin
				for (int i = 0; i < STREAM_BYTES; i++) begin
					bus_write(slot_addr(SLOT_UART, 0), data_t'(sent[i]), lat);
					lats[i] = lat;
				end
				// queue full again right after the delayed write
				bus_read(slot_addr(SLOT_UART, 1), rd, lat);
				check_value("wb_dat_o", rd, data_t'(UART_FIFO_DEPTH) | 32'h200);
			end
			begin
				for (int i = 0; i < STREAM_BYTES; i++)
					receive_frame(got[i]);
			end
		join
		// the queue plus the byte in the phy take writes without delay
		for (int i = 0; i < STREAM_BYTES; i++) begin
			check_value("uart_tx_o byte", data_t'(got[i]), data_t'(sent[i]));
			if (i <= UART_FIFO_DEPTH) begin
				check_value("wb_ack_o latency", data_t'(lats[i]), 32'd1);
			end else begin
				assert (lats[i] > 1)
				else begin
					$display("write %0d to a full queue was acked without delay", i);
					errors++;
				end
			end
		end
		bus_read(slot_addr(SLOT_UART, 1), rd, lat);
		check_value("wb_dat_o", rd, 32'h100);
		finish_test("uart streaming");

		w = $urandom | 32'h1;
		bus_write(slot_addr(SLOT_GPIO, 0), w, lat);
		sent[0] = byte_t'($urandom);
		sent[1] = byte_t'($urandom);
		fork
			begin
				bus_write(slot_addr(SLOT_UART, 0), data_t'(sent[0]), lat);
				bus_write(slot_addr(SLOT_UART, 0), data_t'(sent[1]), lat);
				// request bit 1 alone is a warm reset
				bus_write(slot_addr(SLOT_DEVTBL, DEVTBL_CTRL_OFFS), 32'h2, lat);
				wait_reset_rise();
				check_reset_hold();
				check_value("gp_o", data_t'(gp_out), 32'd0);
				bus_read(slot_addr(SLOT_GPIO, 0), rd, lat);
				check_value("wb_dat_o", rd, 32'd0);
				bus_read(slot_addr(SLOT_DEVTBL, DEVTBL_CTRL_OFFS), rd, lat);
				check_value("wb_dat_o", rd, 32'd0);
			end
			begin
				receive_frame(got[0]);
				receive_frame(got[1]);
			end
		join
		check_value("uart_tx_o byte", data_t'(got[0]), data_t'(sent[0]));
		check_value("uart_tx_o byte", data_t'(got[1]), data_t'(sent[1]));
		finish_test("software warm reset");

		// request bit 0 alone is power-off
		bus_write(slot_addr(SLOT_DEVTBL, DEVTBL_CTRL_OFFS), 32'h1, lat);
		wait_reset_rise();
		held = 0;
		repeat (100) begin
			@(negedge clk);
			if (dev_rst)
				held++;
		end
		check_value("dev_rst_o high cycles", data_t'(held), 32'd100);
		apply_reset();
		check_reset_hold();
		finish_test("power-off");

		$display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
hw/soc_pkg.sv
hw/reset_seq.sv
hw/bus_decoder.sv
hw/dev_table.sv
hw/gpio_port.sv
hw/uart_tx_queue.sv
hw/uart_tx_phy.sv
hw/soc_top.sv
sim/tb_soc.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_soc
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: simulate clean

# the run passes only if the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
